/* src/rv_consts.svh */
// Opcode, funct, ALU, write-back and next-PC codes
// CSR counter numbers and program counter reset values
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_OP     7'b0110011
`define RV_OP_IMM    7'b0010011
`define RV_OP_SYSTEM 7'b1110011

`define RV_F3_CSRRS  3'b010     // Only form used for counter reads
`define RV_F7_BASE   7'b0000000
`define RV_F7_ALT    7'b0100000 // SUB and SRA

`define RV_ALU_ADD   4'd0
`define RV_ALU_SUB   4'd1
`define RV_ALU_SLL   4'd2
`define RV_ALU_SLT   4'd3
`define RV_ALU_SLTU  4'd4
`define RV_ALU_XOR   4'd5
`define RV_ALU_SRL   4'd6
`define RV_ALU_SRA   4'd7
`define RV_ALU_OR    4'd8
`define RV_ALU_AND   4'd9

`define RV_WB_ALU    3'd0
`define RV_WB_IMM    3'd1
`define RV_WB_PC_IMM 3'd2 // AUIPC
`define RV_WB_PC4    3'd3
`define RV_WB_LOAD   3'd4
`define RV_WB_CSR    3'd5

`define RV_PC_SEQ    2'd0
`define RV_PC_BRANCH 2'd1
`define RV_PC_JAL    2'd2
`define RV_PC_JALR   2'd3

`define RV_CSR_CYCLE    12'hC00
`define RV_CSR_TIME     12'hC01
`define RV_CSR_INSTRET  12'hC02
`define RV_CSR_CYCLEH   12'hC80
`define RV_CSR_TIMEH    12'hC81
`define RV_CSR_INSTRETH 12'hC82

`define RV_RESET_PC  32'h0000_0000
`define RV_PC_STEP   32'd4

`endif

/* src/rv_isa_pkg.sv */
// ISA level vector types for words, register indices, byte lanes and counters
package rv_isa_pkg;

	typedef logic [31:0] word_t;      // Data or address word
	typedef logic [4:0]  reg_idx_t;   // Register file index
	typedef logic [3:0]  byte_mask_t; // One bit per byte lane
	typedef logic [63:0] counter_t;   // Cycle and instret width
	typedef logic [2:0]  funct3_t;

endpackage

/* src/rv_exec_pkg.sv */
// Datapath control types passed from decode to the execute blocks
package rv_exec_pkg;

	typedef logic [3:0] alu_op_t;  // RV_ALU_* codes
	typedef logic [2:0] wb_sel_t;  // RV_WB_* codes
	typedef logic [1:0] pc_sel_t;  // RV_PC_* codes

	// Bit 1 picks the high half, bit 0 picks instret over cycle
	typedef logic [1:0] csr_sel_t;

endpackage

/* src/rv_ctrl_if.sv */
// Decoded control bundle with one modport per execute block
`timescale 1ns/1ps

interface rv_ctrl_if;

	rv_exec_pkg::alu_op_t  alu_op;
	logic                  alu_use_imm; // OP-IMM takes imm as operand b
	rv_isa_pkg::word_t     imm;         // Already selected per format
	rv_exec_pkg::wb_sel_t  wb_sel;
	rv_exec_pkg::pc_sel_t  pc_sel;
	logic                  is_branch;
	logic                  is_load;
	logic                  is_store;
	rv_isa_pkg::funct3_t   funct3;
	rv_exec_pkg::csr_sel_t csr_sel;
	logic                  legal;

	modport dec (
		output alu_op, alu_use_imm, imm, wb_sel, pc_sel,
		output is_branch, is_load, is_store, funct3, csr_sel, legal
	);
	modport alu (input alu_op, alu_use_imm, imm, is_branch, funct3);
	modport lsu (input imm, is_load, is_store, funct3);
	modport ret (input imm, wb_sel, pc_sel, csr_sel, legal);

endinterface

/* src/rv_decode.sv */
// RV32I decoder with field split, immediates, legality check and operand strobes
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_decode (
	input  rv_isa_pkg::word_t    insn,
	input  logic                 insn_valid,
	rv_ctrl_if.dec               ctrl,
	output rv_isa_pkg::reg_idx_t rs1_addr,
	output rv_isa_pkg::reg_idx_t rs2_addr,
	output rv_isa_pkg::reg_idx_t rd_addr,
	output logic                 rs1_valid,
	output logic                 rs2_valid,
	output logic                 rd_valid,
	output logic                 rs1_request,
	output logic                 rs2_request,
	output logic                 rd_request
);

	logic [6:0]          opcode;
	rv_isa_pkg::funct3_t funct3;
	logic [6:0]          funct7;
	logic [11:0]         csr_num;
	rv_isa_pkg::word_t   imm_i;
	rv_isa_pkg::word_t   imm_s;
	rv_isa_pkg::word_t   imm_b;
	rv_isa_pkg::word_t   imm_j;
	rv_isa_pkg::word_t   imm_u;
	logic                is_op_imm;
	logic                use_rs1; // Operand use before insn_valid gating
	logic                use_rs2;
	logic                use_rd;

	assign opcode  = insn[6:0];
	assign funct3  = insn[14:12];
	assign funct7  = insn[31:25];
	assign csr_num = insn[31:20];

	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};

	assign is_op_imm        = (opcode == `RV_OP_IMM);
	assign ctrl.alu_use_imm = is_op_imm;
	assign ctrl.funct3      = funct3;
	assign ctrl.csr_sel     = {csr_num[7], csr_num[1]}; // TIME maps onto cycle
	assign ctrl.is_branch   = insn_valid && (opcode == `RV_OP_BRANCH);
	assign ctrl.is_load     = insn_valid && (opcode == `RV_OP_LOAD);
	assign ctrl.is_store    = insn_valid && (opcode == `RV_OP_STORE);

	always_comb begin
		case (funct3)
			3'b000:  ctrl.alu_op = (!is_op_imm && funct7[5]) ? `RV_ALU_SUB : `RV_ALU_ADD;
			3'b001:  ctrl.alu_op = `RV_ALU_SLL;
			3'b010:  ctrl.alu_op = `RV_ALU_SLT;
			3'b011:  ctrl.alu_op = `RV_ALU_SLTU;
			3'b100:  ctrl.alu_op = `RV_ALU_XOR;
			3'b101:  ctrl.alu_op = funct7[5] ? `RV_ALU_SRA : `RV_ALU_SRL;
			3'b110:  ctrl.alu_op = `RV_ALU_OR;
			default: ctrl.alu_op = `RV_ALU_AND;
		endcase
	end

	always_comb begin
		ctrl.legal  = 1'b0;
		ctrl.imm    = imm_i;
		ctrl.wb_sel = `RV_WB_ALU;
		ctrl.pc_sel = `RV_PC_SEQ;
		use_rs1     = 1'b0;
		use_rs2     = 1'b0;
		use_rd      = 1'b0;
		case (opcode)
			`RV_OP_LUI: begin
				ctrl.legal  = 1'b1;
				ctrl.imm    = imm_u;
				ctrl.wb_sel = `RV_WB_IMM;
				use_rd      = 1'b1;
			end
			`RV_OP_AUIPC: begin
				ctrl.legal  = 1'b1;
				ctrl.imm    = imm_u;
				ctrl.wb_sel = `RV_WB_PC_IMM;
				use_rd      = 1'b1;
			end
			`RV_OP_JAL: begin
				ctrl.legal  = 1'b1;
				ctrl.imm    = imm_j;
				ctrl.wb_sel = `RV_WB_PC4;
				ctrl.pc_sel = `RV_PC_JAL;
				use_rd      = 1'b1;
			end
			`RV_OP_JALR: begin
				ctrl.legal  = (funct3 == 3'b000);
				ctrl.wb_sel = `RV_WB_PC4;
				ctrl.pc_sel = `RV_PC_JALR;
				use_rs1     = 1'b1;
				use_rd      = 1'b1;
			end
			`RV_OP_BRANCH: begin
				ctrl.legal  = (funct3[2:1] != 2'b01); // 010 and 011 are reserved
				ctrl.imm    = imm_b;
				ctrl.pc_sel = `RV_PC_BRANCH;
				use_rs1     = 1'b1;
				use_rs2     = 1'b1;
			end
			`RV_OP_LOAD: begin
				ctrl.legal  = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
				ctrl.wb_sel = `RV_WB_LOAD;
				use_rs1     = 1'b1;
				use_rd      = 1'b1;
			end
			`RV_OP_STORE: begin
				ctrl.legal = !funct3[2] && (funct3[1:0] != 2'b11); // SB, SH, SW
				ctrl.imm   = imm_s;
				use_rs1    = 1'b1;
				use_rs2    = 1'b1;
			end
			`RV_OP_OP, `RV_OP_IMM: begin
				use_rs1 = 1'b1;
				use_rs2 = !is_op_imm;
				use_rd  = 1'b1;
				case (funct3)
					3'b000:  ctrl.legal = is_op_imm || funct7 == `RV_F7_BASE ||
					                      funct7 == `RV_F7_ALT;
					3'b001:  ctrl.legal = (funct7 == `RV_F7_BASE);
					3'b101:  ctrl.legal = (funct7 == `RV_F7_BASE) || (funct7 == `RV_F7_ALT);
					default: ctrl.legal = is_op_imm || funct7 == `RV_F7_BASE;
				endcase
			end
			`RV_OP_SYSTEM: begin
				ctrl.wb_sel = `RV_WB_CSR;
				use_rd      = 1'b1;
				// Counter reads only, as CSRRS with rs1 = x0
				if (insn[19:15] == 5'd0 && funct3 == `RV_F3_CSRRS) begin
					case (csr_num)
						`RV_CSR_CYCLE, `RV_CSR_TIME, `RV_CSR_INSTRET,
						`RV_CSR_CYCLEH, `RV_CSR_TIMEH, `RV_CSR_INSTRETH: ctrl.legal = 1'b1;
						default: ctrl.legal = 1'b0;
					endcase
				end
			end
			default: ctrl.legal = 1'b0;
		endcase
	end

	assign rs1_valid = insn_valid && use_rs1;
	assign rs2_valid = insn_valid && use_rs2;
	assign rd_valid  = insn_valid && use_rd;

	assign rs1_addr = rs1_valid ? insn[19:15] : '0; // Zero when unused
	assign rs2_addr = rs2_valid ? insn[24:20] : '0;
	assign rd_addr  = rd_valid  ? insn[11:7]  : '0;

	assign rs1_request = rs1_valid && (rs1_addr != '0);
	assign rs2_request = rs2_valid && (rs2_addr != '0);
	assign rd_request  = rd_valid  && (rd_addr  != '0);

endmodule

/* src/rv_alu.sv */
// Integer ALU for OP and OP-IMM plus the branch condition compare
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_alu (
	rv_ctrl_if.alu            ctrl,
	input  rv_isa_pkg::word_t rs1_value,
	input  rv_isa_pkg::word_t rs2_value,
	output rv_isa_pkg::word_t alu_result,
	output logic              branch_taken
);

	rv_isa_pkg::word_t op_b;
	logic [4:0]        shamt;
	logic              eq;
	logic              lt;
	logic              ltu;
	logic              cond;

	assign op_b  = ctrl.alu_use_imm ? ctrl.imm : rs2_value;
	assign shamt = op_b[4:0];

	// Branches never use the immediate, so op_b is rs2 for them
	assign eq  = (rs1_value == op_b);
	assign lt  = ($signed(rs1_value) < $signed(op_b));
	assign ltu = (rs1_value < op_b);

	always_comb begin
		case (ctrl.alu_op)
			`RV_ALU_ADD:  alu_result = rs1_value + op_b;
			`RV_ALU_SUB:  alu_result = rs1_value - op_b;
			`RV_ALU_SLL:  alu_result = rs1_value << shamt;
			`RV_ALU_SLT:  alu_result = {31'b0, lt};
			`RV_ALU_SLTU: alu_result = {31'b0, ltu};
			`RV_ALU_XOR:  alu_result = rs1_value ^ op_b;
			`RV_ALU_SRL:  alu_result = rs1_value >> shamt;
			`RV_ALU_SRA:  alu_result = $signed(rs1_value) >>> shamt; // Sign fill
			`RV_ALU_OR:   alu_result = rs1_value | op_b;
			`RV_ALU_AND:  alu_result = rs1_value & op_b;
			default:      alu_result = '0;
		endcase
	end

	always_comb begin
		case (ctrl.funct3)
			3'b000:  cond = eq;   // BEQ
			3'b001:  cond = !eq;  // BNE
			3'b100:  cond = lt;   // BLT
			3'b101:  cond = !lt;  // BGE
			3'b110:  cond = ltu;  // BLTU
			3'b111:  cond = !ltu; // BGEU
			default: cond = 1'b0;
		endcase
	end

	assign branch_taken = ctrl.is_branch && cond;

endmodule

/* src/rv_lsu.sv */
// Load/store unit with address add, byte lane masks and load extension
`timescale 1ns/1ps

module rv_lsu (
	rv_ctrl_if.lsu                 ctrl,
	input  rv_isa_pkg::word_t      rs1_value,
	input  rv_isa_pkg::word_t      rs2_value,
	output logic                   mem_valid,
	output rv_isa_pkg::word_t      mem_addr,
	output rv_isa_pkg::word_t      mem_wdata,
	output rv_isa_pkg::byte_mask_t mem_wstrb,
	output rv_isa_pkg::byte_mask_t mem_rmask,
	input  rv_isa_pkg::word_t      mem_rdata,
	output rv_isa_pkg::word_t      load_data
);

	rv_isa_pkg::byte_mask_t size_mask;

	assign mem_valid = ctrl.is_load || ctrl.is_store;
	assign mem_addr  = mem_valid ? rs1_value + ctrl.imm : '0; // imm is I or S form
	assign mem_wdata = ctrl.is_store ? rs2_value : '0;

	always_comb begin
		case (ctrl.funct3[1:0])
			2'b00:   size_mask = 4'b0001;
			2'b01:   size_mask = 4'b0011;
			2'b10:   size_mask = 4'b1111;
			default: size_mask = 4'b0000;
		endcase
	end

	// Reserved sizes leave both masks clear
	assign mem_wstrb = (ctrl.is_store && !ctrl.funct3[2]) ? size_mask : '0;
	assign mem_rmask = (ctrl.is_load && ctrl.funct3[2:1] != 2'b11) ? size_mask : '0;

	always_comb begin
		case (ctrl.funct3)
			3'b000:  load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};   // LB
			3'b001:  load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]}; // LH
			3'b010:  load_data = mem_rdata;                              // LW
			3'b100:  load_data = {24'b0, mem_rdata[7:0]};                // LBU
			3'b101:  load_data = {16'b0, mem_rdata[15:0]};               // LHU
			default: load_data = '0;
		endcase
	end

	masks_exclusive: assert final (mem_wstrb == '0 || mem_rmask == '0)
		else $error("read and write byte masks both set");

endmodule

/* src/rv_retire.sv */
// Completion and trap logic, next-PC select, PC register and 64-bit counters
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_retire (
	input  logic              clk,
	input  logic              rst,
	rv_ctrl_if.ret            ctrl,
	input  logic              insn_valid,
	input  logic              rs1_valid,
	input  logic              rs2_valid,
	input  logic              rd_valid,
	input  logic              rs1_ready,
	input  logic              rs2_ready,
	input  logic              rd_ready,
	input  logic              mem_valid,
	input  logic              mem_ready,
	input  logic              branch_taken,
	input  rv_isa_pkg::word_t rs1_value,
	input  rv_isa_pkg::word_t alu_result,
	input  rv_isa_pkg::word_t load_data,
	output rv_isa_pkg::word_t insn_addr,
	output rv_isa_pkg::word_t rd_wdata,
	output logic              insn_complete,
	output logic              trap
);

	rv_isa_pkg::word_t    pc_q;
	rv_isa_pkg::word_t    pc_next;
	rv_isa_pkg::word_t    pc_plus4;
	rv_isa_pkg::word_t    pc_target;   // PC plus imm, shared by JAL, branch, AUIPC
	rv_isa_pkg::word_t    jalr_target;
	rv_isa_pkg::word_t    csr_value;
	rv_isa_pkg::counter_t csr_counter;
	rv_isa_pkg::counter_t cycle_q;
	rv_isa_pkg::counter_t instret_q;
	logic                 halted_q;    // Sticky after a trap
	logic                 retire;

	assign insn_addr     = pc_q;
	assign insn_complete = insn_valid && (!rs1_valid || rs1_ready) &&
	                       (!rs2_valid || rs2_ready) && (!rd_valid || rd_ready) &&
	                       (!mem_valid || mem_ready);
	assign trap          = insn_valid && !ctrl.legal;
	assign retire        = insn_complete && !trap && !halted_q;

	assign pc_plus4    = pc_q + `RV_PC_STEP;
	assign pc_target   = pc_q + ctrl.imm;
	assign jalr_target = rs1_value + ctrl.imm;

	always_comb begin
		case (ctrl.pc_sel)
			`RV_PC_BRANCH: pc_next = branch_taken ? {pc_target[31:1], 1'b0} : pc_plus4;
			`RV_PC_JAL:    pc_next = pc_target;
			`RV_PC_JALR:   pc_next = {jalr_target[31:1], 1'b0};
			default:       pc_next = pc_plus4;
		endcase
	end

	assign csr_counter = ctrl.csr_sel[0] ? instret_q : cycle_q;
	assign csr_value   = ctrl.csr_sel[1] ? csr_counter[63:32] : csr_counter[31:0];

	always_comb begin
		case (ctrl.wb_sel)
			`RV_WB_IMM:    rd_wdata = ctrl.imm;  // LUI
			`RV_WB_PC_IMM: rd_wdata = pc_target;
			`RV_WB_PC4:    rd_wdata = pc_plus4;  // Link address
			`RV_WB_LOAD:   rd_wdata = load_data;
			`RV_WB_CSR:    rd_wdata = csr_value;
			default:       rd_wdata = alu_result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q      <= `RV_RESET_PC;
			cycle_q   <= '0;
			instret_q <= '0;
			halted_q  <= 1'b0;
		end else begin
			cycle_q <= cycle_q + 1'b1;
			if (retire) begin
				pc_q      <= pc_next;
				instret_q <= instret_q + 1'b1;
			end
			if (trap)
				halted_q <= 1'b1;
		end
	end

	// The next-PC mux only looks at branch_taken under the branch select
	taken_needs_branch_sel: assert property (@(posedge clk) disable iff (rst)
		branch_taken |-> ctrl.pc_sel == `RV_PC_BRANCH)
		else $error("branch taken without the branch next-PC select");

endmodule

/* src/rv_core.sv */
// Single-cycle RV32I execute unit top level with decode, ALU, LSU and retire
`timescale 1ns/1ps

module rv_core (
	input  logic                   clk,
	input  logic                   rst,
	output rv_isa_pkg::word_t      insn_addr,
	input  rv_isa_pkg::word_t      insn,
	input  logic                   insn_valid,
	output logic                   insn_complete,
	output logic                   trap,
	output rv_isa_pkg::reg_idx_t   rs1_addr,
	output rv_isa_pkg::reg_idx_t   rs2_addr,
	output rv_isa_pkg::reg_idx_t   rd_addr,
	output logic                   rs1_request,
	output logic                   rs2_request,
	output logic                   rd_request,
	input  rv_isa_pkg::word_t      rs1_rdata,
	input  rv_isa_pkg::word_t      rs2_rdata,
	output rv_isa_pkg::word_t      rd_wdata,
	input  logic                   rs1_ready,
	input  logic                   rs2_ready,
	input  logic                   rd_ready,
	output logic                   mem_valid,
	input  logic                   mem_ready,
	output rv_isa_pkg::word_t      mem_addr,
	output rv_isa_pkg::word_t      mem_wdata,
	output rv_isa_pkg::byte_mask_t mem_wstrb,
	output rv_isa_pkg::byte_mask_t mem_rmask,
	input  rv_isa_pkg::word_t      mem_rdata
);

	rv_isa_pkg::word_t rs1_value;
	rv_isa_pkg::word_t rs2_value;
	rv_isa_pkg::word_t alu_result;
	rv_isa_pkg::word_t load_data;
	logic              rs1_valid;
	logic              rs2_valid;
	logic              rd_valid;
	logic              branch_taken;

	rv_ctrl_if u_ctrl ();

	// x0 always reads as zero, whatever the register file returns
	assign rs1_value = (rs1_addr == '0) ? '0 : rs1_rdata;
	assign rs2_value = (rs2_addr == '0) ? '0 : rs2_rdata;

	rv_decode u_decode (
		.insn        (insn),
		.insn_valid  (insn_valid),
		.ctrl        (u_ctrl.dec),
		.rs1_addr    (rs1_addr),
		.rs2_addr    (rs2_addr),
		.rd_addr     (rd_addr),
		.rs1_valid   (rs1_valid),
		.rs2_valid   (rs2_valid),
		.rd_valid    (rd_valid),
		.rs1_request (rs1_request),
		.rs2_request (rs2_request),
		.rd_request  (rd_request)
	);

	rv_alu u_alu (
		.ctrl         (u_ctrl.alu),
		.rs1_value    (rs1_value),
		.rs2_value    (rs2_value),
		.alu_result   (alu_result),
		.branch_taken (branch_taken)
	);

	rv_lsu u_lsu (
		.ctrl      (u_ctrl.lsu),
		.rs1_value (rs1_value),
		.rs2_value (rs2_value),
		.mem_valid (mem_valid),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb),
		.mem_rmask (mem_rmask),
		.mem_rdata (mem_rdata),
		.load_data (load_data)
	);

	rv_retire u_retire (
		.clk           (clk),
		.rst           (rst),
		.ctrl          (u_ctrl.ret),
		.insn_valid    (insn_valid),
		.rs1_valid     (rs1_valid),
		.rs2_valid     (rs2_valid),
		.rd_valid      (rd_valid),
		.rs1_ready     (rs1_ready),
		.rs2_ready     (rs2_ready),
		.rd_ready      (rd_ready),
		.mem_valid     (mem_valid),
		.mem_ready     (mem_ready),
		.branch_taken  (branch_taken),
		.rs1_value     (rs1_value),
		.alu_result    (alu_result),
		.load_data     (load_data),
		.insn_addr     (insn_addr),
		.rd_wdata      (rd_wdata),
		.insn_complete (insn_complete),
		.trap          (trap)
	);

endmodule

/* tests/rv_core_tb.sv */
// Vector-driven testbench for rv_core with random ready stalls
// Tracks PC, cycle and instret to check retirement and counter reads
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_tb;

	localparam int MAX_VECTORS       = 64;
	localparam int RESET_CYCLES      = 16;
	localparam int CYCLES_PER_VECTOR = 8;

	logic        clk;
	logic        rst;
	logic [31:0] insn_addr;
	logic [31:0] insn;
	logic        insn_valid;
	logic        insn_complete;
	logic        trap;
	logic [4:0]  rs1_addr;
	logic [4:0]  rs2_addr;
	logic [4:0]  rd_addr;
	logic        rs1_request;
	logic        rs2_request;
	logic        rd_request;
	logic [31:0] rs1_rdata;
	logic [31:0] rs2_rdata;
	logic [31:0] rd_wdata;
	logic        rs1_ready;
	logic        rs2_ready;
	logic        rd_ready;
	logic        mem_valid;
	logic        mem_ready;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_wstrb;
	logic [3:0]  mem_rmask;
	logic [31:0] mem_rdata;

	// One entry per vector file column
	logic [31:0] v_insn      [MAX_VECTORS];
	logic [31:0] v_rs1       [MAX_VECTORS];
	logic [31:0] v_rs2       [MAX_VECTORS];
	logic [31:0] v_mem_rdata [MAX_VECTORS];
	logic [3:0]  v_rd_chk    [MAX_VECTORS]; // 0 none, 1 compare, 2 counter read
	logic [31:0] v_rd        [MAX_VECTORS];
	logic [31:0] v_addr      [MAX_VECTORS];
	logic [3:0]  v_wstrb     [MAX_VECTORS];
	logic [3:0]  v_rmask     [MAX_VECTORS];
	logic [3:0]  v_trap      [MAX_VECTORS];
	logic [3:0]  v_pc_change [MAX_VECTORS];
	logic [31:0] v_next_pc   [MAX_VECTORS];

	int          num_vectors;
	int          fail_count;
	int          total_cycles;
	int          cycle_limit;
	logic [63:0] edges_since_reset;
	logic [63:0] retired_count;
	logic [31:0] rng_state;
	logic [31:0] expected_pc;
	logic        halted; // Set once a trap was presented

	rv_core u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// TIME reads the cycle count, as there is no separate timer
	function automatic logic [31:0] counter_read_value(input logic [11:0] csr,
		input logic [63:0] cycles, input logic [63:0] instret);
		case (csr)
			`RV_CSR_CYCLE, `RV_CSR_TIME:   return cycles[31:0];
			`RV_CSR_CYCLEH, `RV_CSR_TIMEH: return cycles[63:32];
			`RV_CSR_INSTRET:               return instret[31:0];
			default:                       return instret[63:32];
		endcase
	endfunction

	// Register operands of each instruction format, as {rs1, rs2, rd}
	function automatic logic [2:0] operand_use(input logic [6:0] opcode);
		case (opcode)
			`RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_JAL, `RV_OP_SYSTEM: return 3'b001;
			`RV_OP_JALR, `RV_OP_LOAD, `RV_OP_IMM:                return 3'b101;
			`RV_OP_BRANCH, `RV_OP_STORE:                         return 3'b110;
			`RV_OP_OP:                                           return 3'b111;
			default:                                             return 3'b000;
		endcase
	endfunction

	task automatic end_with_failure();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string what);
		fail_count++;
		$display("CHECK FAILED at %0t ns: %s", $time, what);
		end_with_failure();
	endtask

	task automatic set_readies(input logic level);
		rs1_ready = level;
		rs2_ready = level;
		rd_ready  = level;
		mem_ready = level;
	endtask

	task automatic load_vectors();
		int    fd;
		int    code;
		int    fields;
		string line;
		fd = $fopen("tests/rv_core_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file tests/rv_core_vectors.txt");
			end_with_failure();
		end
		num_vectors = 0;
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
				if (num_vectors >= MAX_VECTORS) begin
					$display("Vector file holds more than %0d vectors", MAX_VECTORS);
					end_with_failure();
				end
				fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
					v_insn[num_vectors], v_rs1[num_vectors], v_rs2[num_vectors],
					v_mem_rdata[num_vectors], v_rd_chk[num_vectors], v_rd[num_vectors],
					v_addr[num_vectors], v_wstrb[num_vectors], v_rmask[num_vectors],
					v_trap[num_vectors], v_pc_change[num_vectors], v_next_pc[num_vectors]);
				if (fields != 12) begin
					$display("Vector line %0d has %0d fields instead of 12", num_vectors, fields);
					end_with_failure();
				end
				num_vectors++;
			end
		end
		$fclose(fd);
	endtask

	// Register indices go out when used, requests only for nonzero indices
	task automatic check_operands(input int i);
		logic [2:0] used;
		logic [4:0] rs1_idx;
		logic [4:0] rs2_idx;
		logic [4:0] rd_idx;
		used    = operand_use(v_insn[i][6:0]);
		rs1_idx = v_insn[i][19:15];
		rs2_idx = v_insn[i][24:20];
		rd_idx  = v_insn[i][11:7];
		assert ((!used[2] || rs1_addr == rs1_idx) &&
		        rs1_request == (used[2] && rs1_idx != 5'd0))
			else report_mismatch($sformatf("vector %0d: rs1_addr/rs1_request %h/%b",
				i, rs1_addr, rs1_request));
		assert ((!used[1] || rs2_addr == rs2_idx) &&
		        rs2_request == (used[1] && rs2_idx != 5'd0))
			else report_mismatch($sformatf("vector %0d: rs2_addr/rs2_request %h/%b",
				i, rs2_addr, rs2_request));
		assert ((!used[0] || rd_addr == rd_idx) &&
		        rd_request == (used[0] && rd_idx != 5'd0))
			else report_mismatch($sformatf("vector %0d: rd_addr/rd_request %h/%b",
				i, rd_addr, rd_request));
	endtask

	task automatic check_results(input int i);
		logic [31:0] exp_rd;
		logic [31:0] exp_wdata;
		exp_wdata = (v_wstrb[i] != 4'd0) ? v_rs2[i] : 32'd0; // Store data passes unshifted
		exp_rd    = (v_rd_chk[i] == 4'd2) ?
		            counter_read_value(v_insn[i][31:20], edges_since_reset, retired_count) :
		            v_rd[i];
		assert (trap == v_trap[i][0])
			else report_mismatch($sformatf("vector %0d: trap is %b", i, trap));
		assert (insn_complete)
			else report_mismatch($sformatf("vector %0d: not complete with all readies high", i));
		assert (mem_valid == (v_wstrb[i] != 4'd0 || v_rmask[i] != 4'd0))
			else report_mismatch($sformatf("vector %0d: mem_valid is %b", i, mem_valid));
		assert (mem_addr == v_addr[i])
			else report_mismatch($sformatf("vector %0d: mem_addr %h, expected %h",
				i, mem_addr, v_addr[i]));
		assert (mem_wstrb == v_wstrb[i] && mem_rmask == v_rmask[i])
			else report_mismatch($sformatf("vector %0d: wstrb/rmask %h/%h, expected %h/%h",
				i, mem_wstrb, mem_rmask, v_wstrb[i], v_rmask[i]));
		assert (mem_wdata == exp_wdata)
			else report_mismatch($sformatf("vector %0d: mem_wdata %h, expected %h",
				i, mem_wdata, exp_wdata));
		check_operands(i);
		if (v_rd_chk[i] != 4'd0) begin
			assert (rd_wdata == exp_rd)
				else report_mismatch($sformatf("vector %0d: rd_wdata %h, expected %h",
					i, rd_wdata, exp_rd));
		end
	endtask

	// Called on a falling edge, returns on the falling edge after retirement
	task automatic run_vector(input int i);
		int stall;
		rng_state = xorshift32(rng_state);
		stall     = int'(rng_state % 4);
		insn       = v_insn[i];
		insn_valid = 1'b1;
		rs1_rdata  = v_rs1[i];
		rs2_rdata  = v_rs2[i];
		mem_rdata  = v_mem_rdata[i];
		set_readies(1'b0);
		repeat (stall) begin
			#1;
			assert (v_trap[i][0] || !insn_complete)
				else report_mismatch($sformatf("vector %0d: complete while stalled", i));
			@(negedge clk);
			assert (insn_addr == expected_pc)
				else report_mismatch($sformatf("vector %0d: PC %h moved while stalled",
					i, insn_addr));
		end
		set_readies(1'b1);
		#1;
		check_results(i);
		@(negedge clk);
		if (v_pc_change[i][0])
			expected_pc = v_next_pc[i];
		assert (insn_addr == expected_pc)
			else report_mismatch($sformatf("vector %0d: insn_addr %h, expected %h",
				i, insn_addr, expected_pc));
		if (v_trap[i][0])
			halted = 1'b1;
		else if (!halted)
			retired_count++;
	endtask

	always @(posedge clk) begin
		if (rst)
			edges_since_reset <= '0;
		else
			edges_since_reset <= edges_since_reset + 1'b1;
	end

	always @(posedge clk) begin
		total_cycles <= total_cycles + 1;
		if (total_cycles >= cycle_limit) begin
			$display("Timeout after %0d clock cycles without reaching the end", total_cycles);
			end_with_failure();
		end
	end

	initial begin
		rst          = 1'b1;
		insn         = '0;
		insn_valid   = 1'b0;
		rs1_rdata    = '0;
		rs2_rdata    = '0;
		mem_rdata    = '0;
		set_readies(1'b0);
		fail_count    = 0;
		total_cycles  = 0;
		cycle_limit   = RESET_CYCLES + CYCLES_PER_VECTOR * MAX_VECTORS;
		rng_state     = 32'd13181;
		expected_pc   = `RV_RESET_PC;
		retired_count = '0;
		halted        = 1'b0;
		load_vectors();
		cycle_limit = RESET_CYCLES + 2 + CYCLES_PER_VECTOR * num_vectors;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#1;
		assert (!rs1_request && !rs2_request && !rd_request && !mem_valid && !trap)
			else report_mismatch("strobe or trap high while idle after reset");
		assert (mem_wstrb == 4'd0 && mem_rmask == 4'd0)
			else report_mismatch("byte masks set while idle after reset");
		assert (insn_addr == `RV_RESET_PC)
			else report_mismatch($sformatf("insn_addr %h after reset", insn_addr));
		@(negedge clk);
		for (int i = 0; i < num_vectors; i++)
			run_vector(i);
		if (fail_count == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			end_with_failure();
		end
	end

endmodule

/* all.f */
+incdir+src
src/rv_isa_pkg.sv
src/rv_exec_pkg.sv
src/rv_ctrl_if.sv
src/rv_decode.sv
src/rv_alu.sv
src/rv_lsu.sv
src/rv_retire.sv
src/rv_core.sv
tests/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - src
    files:
      - src/rv_isa_pkg.sv
      - src/rv_exec_pkg.sv
      - src/rv_ctrl_if.sv
      - src/rv_decode.sv
      - src/rv_alu.sv
      - src/rv_lsu.sv
      - src/rv_retire.sv
      - src/rv_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/rv_core_tb.sv

/* tests/rv_core_vectors.txt */
# insn rs1 rs2 mem_rdata rd_chk rd_wdata mem_addr wstrb rmask trap pc_change next_pc
# rd_chk: 0 no rd check, 1 compare rd_wdata, 2 counter read tracked by the testbench
00510093 0000000a 00000000 00000000 1 0000000f 00000000 0 0 0 1 00000004
002081b3 00000010 00000020 00000000 1 00000030 00000000 0 0 0 1 00000008
40208233 00000005 00000007 00000000 1 fffffffe 00000000 0 0 0 1 0000000c
4040d293 80000000 00000000 00000000 1 f8000000 00000000 0 0 0 1 00000010
0020b333 00000001 ffffffff 00000000 1 00000001 00000000 0 0 0 1 00000014
002093b3 00000003 00000024 00000000 1 00000030 00000000 0 0 0 1 00000018
12345437 00000000 00000000 00000000 1 12345000 00000000 0 0 0 1 0000001c
00001497 00000000 00000000 00000000 1 0000101c 00000000 0 0 0 1 00000020
00108013 00000040 00000000 00000000 1 00000041 00000000 0 0 0 1 00000024
0080a503 00001000 00000000 deadbeef 1 deadbeef 00001008 0 f 0 1 00000028
fff08583 00001001 00000000 12345680 1 ffffff80 00001000 0 1 0 1 0000002c
0020d603 00002000 00000000 abcd8001 1 00008001 00002002 0 3 0 1 00000030
00009683 00003000 00000000 00008001 1 ffff8001 00003000 0 3 0 1 00000034
0030c703 00000100 00000000 000000f0 1 000000f0 00000103 0 1 0 1 00000038
0020a623 00004000 cafef00d 00000000 0 00000000 0000400c f 0 0 1 0000003c
fe208e23 00004004 000000ab 00000000 0 00000000 00004000 1 0 0 1 00000040
00209323 00005000 00001234 00000000 0 00000000 00005006 3 0 0 1 00000044
00208863 00000007 00000007 00000000 0 00000000 00000000 0 0 0 1 00000054
00209863 00000005 00000005 00000000 0 00000000 00000000 0 0 0 1 00000058
fe20cce3 ffffffff 00000001 00000000 0 00000000 00000000 0 0 0 1 00000050
0020f463 00000001 ffffffff 00000000 0 00000000 00000000 0 0 0 1 00000054
100000ef 00000000 00000000 00000000 1 00000058 00000000 0 0 0 1 00000154
005302e7 00000200 00000000 00000000 1 00000158 00000000 0 0 0 1 00000204
c00023f3 00000000 00000000 00000000 2 00000000 00000000 0 0 0 1 00000208
c02023f3 00000000 00000000 00000000 2 00000000 00000000 0 0 0 1 0000020c
c80023f3 00000000 00000000 00000000 2 00000000 00000000 0 0 0 1 00000210
c01023f3 00000000 00000000 00000000 2 00000000 00000000 0 0 0 1 00000214
c82023f3 00000000 00000000 00000000 2 00000000 00000000 0 0 0 1 00000218
c81023f3 00000000 00000000 00000000 2 00000000 00000000 0 0 0 1 0000021c
0000007f 00000000 00000000 00000000 0 00000000 00000000 0 0 1 0 0000021c
00510093 0000000a 00000000 00000000 1 0000000f 00000000 0 0 0 0 0000021c
c02023f3 00000000 00000000 00000000 2 00000000 00000000 0 0 0 0 0000021c
